/* ssd_ctrl_top.f */
+incdir+verification
common/ssd_ctrl_pkg.sv
rtl/cmd_launcher.sv
rtl/watchdog_timer.sv
rtl/core_reset_ctrl.sv
rtl/axil_reg_slave.sv
rtl/ssd_ctrl_top.sv
verification/tb_ssd_ctrl.sv

/* Makefile */
# Verilator simulation of ssd_ctrl_top

SIM := obj_dir/Vtb_ssd_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_ssd_ctrl -f ssd_ctrl_top.f

# fails unless the testbench prints the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

/* verification/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH
`default_nettype none

// hold keeps bready low that many cycles once bvalid is up
task automatic axil_write(input reg_idx_t idx, input word_t data, input int hold);
  logic aw_hit;
  logic w_hit;
  int   t;
  if (timed_out) return;
  awaddr_i  = {27'd0, idx, 2'b00};
  awvalid_i = 1'b1;
  wdata_i   = data;
  wvalid_i  = 1'b1;
  t = 0;
  while ((awvalid_i || wvalid_i) && t < WAIT_LIMIT) begin
    aw_hit = awvalid_i && awready_o;
    w_hit  = wvalid_i && wready_o;
    next_cycle();
    if (aw_hit) awvalid_i = 1'b0;
    if (w_hit) wvalid_i = 1'b0;
    t++;
  end
  t = 0;
  while (!bvalid_o && t < WAIT_LIMIT) begin
    next_cycle();
    t++;
  end
  if (!bvalid_o) begin
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    report_timeout("write was never answered on the b channel");
    return;
  end
  bvalid_cycle = cycle_count;
  check_value("bresp_o", word_t'(bresp_o), '0);
  for (int n = 0; n < hold; n++) begin
    next_cycle();
    check_value("bvalid_o while stalled", word_t'(bvalid_o), 32'd1);
    check_value("aw/w ready while stalled", word_t'({awready_o, wready_o}), '0);
  end
  bready_i = 1'b1;
  next_cycle();
  bready_i = 1'b0;
  check_value("bvalid_o after handshake", word_t'(bvalid_o), '0);
  check_value("aw/w ready after handshake", word_t'({awready_o, wready_o}), 32'd3);
endtask

// rdata itself is checked by the negedge monitor
task automatic axil_read(input reg_idx_t idx, input int hold);
  logic  ar_hit;
  word_t first;
  int    t;
  if (timed_out) return;
  araddr_i  = {27'd0, idx, 2'b00};
  arvalid_i = 1'b1;
  t = 0;
  while (arvalid_i && t < WAIT_LIMIT) begin
    ar_hit = arready_o;
    if (ar_hit) exp_rdata_q.push_back(expected_rdata(idx));
    next_cycle();
    if (ar_hit) arvalid_i = 1'b0;
    t++;
  end
  t = 0;
  while (!rvalid_o && t < WAIT_LIMIT) begin
    next_cycle();
    t++;
  end
  if (!rvalid_o) begin
    arvalid_i = 1'b0;
    report_timeout("read was never answered on the r channel");
    return;
  end
  first = rdata_o;
  check_value("rresp_o", word_t'(rresp_o), '0);
  for (int n = 0; n < hold; n++) begin
    next_cycle();
    check_value("rvalid_o while stalled", word_t'(rvalid_o), 32'd1);
    check_value("rdata_o while stalled", rdata_o, first);
    check_value("arready_o while stalled", word_t'(arready_o), '0);
  end
  rready_i = 1'b1;
  next_cycle();
  rready_i = 1'b0;
  check_value("rvalid_o after handshake", word_t'(rvalid_o), '0);
  check_value("arready_o after handshake", word_t'(arready_o), 32'd1);
endtask

`default_nettype wire
`endif

/* verification/tb_ssd_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_ssd_ctrl
  import ssd_ctrl_pkg::*;
();

  localparam int WAIT_LIMIT = 64;

  logic                  clk = 1'b0;
  logic                  rst_n;
  addr_t                 awaddr_i;
  addr_t                 araddr_i;
  word_t                 wdata_i;
  strb_t                 wstrb_i;
  logic                  awvalid_i, wvalid_i, bready_i, arvalid_i, rready_i;
  logic                  awready_o, wready_o, bvalid_o, arready_o, rvalid_o;
  resp_t                 bresp_o, rresp_o;
  word_t                 rdata_o;
  word_t [NUM_STATE-1:0] core_state_i;
  logic                  core_idle_i, io_switch_button_i;
  logic                  cmd_valid_o, wdt_reset_o, core_switch_o, core_rst_n_o;
  word_t                 cmd_code_o, cmd_data0_o, cmd_data1_o;

  word_t shadow_cmd;
  word_t exp_rdata_q[$];  // one entry per accepted read
  int    cycle_count = 0;
  int    bvalid_cycle = 0;
  int    check_count = 0;
  int    error_count = 0;
  int    test_errors = 0;
  logic  timed_out = 1'b0;

  ssd_ctrl_top #(
    .WDT_TIMEOUT     (200),
    .WDT_PULSE       (8),
    .CORE_RST_CYCLES (10)
  ) dut_i (.*);

  always #10 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // r handshake checked mid cycle
  always @(negedge clk) begin
    if (rvalid_o && rready_i) begin
      if (exp_rdata_q.size() == 0) begin
        $display("read response at %0t with no read outstanding", $time);
        error_count++;
      end else begin
        check_value("rdata_o", rdata_o, exp_rdata_q.pop_front());
      end
    end
  end

  // no core reset while the core is busy
  always @(negedge clk) begin
    if (!core_idle_i)
      check_value("core_rst_n_o while busy", word_t'(core_rst_n_o), 32'd1);
  end

  function automatic word_t expected_rdata(input reg_idx_t idx);
    word_t value;
    case (idx)
      REG_CMD:                                   value = shadow_cmd;
      REG_CODE, REG_DATA0, REG_DATA1, REG_DELAY: value = core_state_i[idx - REG_CODE];
      default:                                   value = '0;
    endcase
    return value;
  endfunction

  task automatic check_value(input string what, input word_t got, input word_t exp);
    check_count++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    error_count++;
    timed_out = 1'b1;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input int num, input string name);
    if (error_count == test_errors)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: %0d errors", num, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  task automatic test_readback();
    word_t value;
    for (int i = 0; i < NUM_STATE; i++) core_state_i[i] = $urandom();
    axil_read(REG_CMD, 0);  // reset value
    for (int n = 0; n < 4; n++) begin
      value = $urandom();
      axil_write(REG_CMD, value, 0);
      shadow_cmd = value;
      axil_read(REG_CMD, 0);
    end
    for (int i = 0; i < NUM_REGS; i++) axil_read(reg_idx_t'(i), 0);
    report_test(1, "register readback");
  endtask

  task automatic test_launch();
    word_t code;
    word_t data0;
    word_t data1;
    int    delay;
    int    t;
    for (int n = 0; n < 5; n++) begin
      code  = $urandom();
      data0 = $urandom();
      data1 = $urandom();
      delay = $urandom_range(20, 0);
      axil_write(REG_CODE, code, 0);
      axil_write(REG_DATA0, data0, 0);
      axil_write(REG_DATA1, data1, 0);
      axil_write(REG_DELAY, word_t'(delay), 0);
      shadow_cmd = $urandom();
      axil_write(REG_CMD, shadow_cmd, 0);
      t = 0;
      while (!cmd_valid_o && t < WAIT_LIMIT) begin
        next_cycle();
        t++;
      end
      if (!cmd_valid_o) begin
        report_timeout("cmd_valid_o never rose after a launch");
        break;
      end
      check_value("launch latency", word_t'(cycle_count - bvalid_cycle), word_t'(delay + 1));
      check_value("cmd_code_o", cmd_code_o, code);
      check_value("cmd_data0_o", cmd_data0_o, data0);
      check_value("cmd_data1_o", cmd_data1_o, data1);
      next_cycle();
      check_value("cmd_valid_o width", word_t'(cmd_valid_o), '0);
    end
    report_test(2, "command launch");
  endtask

  task automatic test_backpressure();
    word_t value;
    for (int n = 0; n < 6; n++) begin
      value = $urandom();
      axil_write(REG_CMD, value, $urandom_range(8, 1));
      shadow_cmd = value;
      axil_read(REG_CMD, $urandom_range(8, 1));
      axil_read(reg_idx_t'($urandom_range(7, 1)), $urandom_range(8, 1));
    end
    report_test(3, "response back-pressure");
  endtask

  task automatic test_watchdog();
    int   t;
    int   high;
    logic prev;
    axil_write(REG_WDT_CLEAR, 32'd1, 0);
    axil_write(REG_WDT_ENABLE, 32'd1, 0);
    for (t = 0; t < 500; t++) begin
      next_cycle();
      check_value("wdt_reset_o while cleared", word_t'(wdt_reset_o), '0);
    end
    axil_write(REG_WDT_CLEAR, 32'd0, 0);
    t = 0;
    while (!wdt_reset_o && t < 250) begin
      next_cycle();
      t++;
    end
    if (!wdt_reset_o) begin
      report_timeout("wdt_reset_o did not rise within 250 cycles");
    end else begin
      high = 0;
      prev = 1'b0;
      while (wdt_reset_o && high < 32) begin
        check_value("core_switch_o in pulse", word_t'(core_switch_o), word_t'(prev));
        prev = wdt_reset_o;
        high++;
        next_cycle();
      end
      check_value("core_switch_o after pulse", word_t'(core_switch_o), word_t'(prev));
      check_value("wdt pulse length", word_t'(high), 32'd8);
    end
    axil_write(REG_WDT_CLEAR, 32'd1, 0);
    report_test(4, "watchdog");
  endtask

  task automatic test_core_reset();
    int t;
    int low;
    core_idle_i = 1'b1;
    t = 0;
    while (core_rst_n_o && t < WAIT_LIMIT) begin
      next_cycle();
      t++;
    end
    if (core_rst_n_o) begin
      report_timeout("core_rst_n_o never went low once the core was idle");
    end else begin
      low = 0;
      while (!core_rst_n_o && low < 40) begin
        low++;
        next_cycle();
      end
      check_value("core reset length", word_t'(low), 32'd10);
      for (t = 0; t < 20; t++) begin
        check_value("core_rst_n_o after sequence", word_t'(core_rst_n_o), 32'd1);
        next_cycle();
      end
    end
    io_switch_button_i = 1'b1;
    check_value("core_switch_o before button", word_t'(core_switch_o), '0);
    next_cycle();
    check_value("core_switch_o after button", word_t'(core_switch_o), 32'd1);
    io_switch_button_i = 1'b0;
    next_cycle();
    check_value("core_switch_o after release", word_t'(core_switch_o), '0);
    report_test(5, "core reset");
  endtask

  initial begin
    void'($urandom(32'h017fa6da));
    rst_n              = 1'b0;
    awaddr_i           = '0;
    awvalid_i          = 1'b0;
    wdata_i            = '0;
    wstrb_i            = '1;
    wvalid_i           = 1'b0;
    bready_i           = 1'b0;
    araddr_i           = '0;
    arvalid_i          = 1'b0;
    rready_i           = 1'b0;
    core_state_i       = '0;
    core_idle_i        = 1'b0;  // core busy until test 5
    io_switch_button_i = 1'b0;
    shadow_cmd         = CMD_RESET_VALUE;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_readback();
    test_launch();
    test_backpressure();
    test_watchdog();
    test_core_reset();
    if (exp_rdata_q.size() != 0) begin
      $display("%0d read responses never arrived", exp_rdata_q.size());
      error_count++;
    end
    $display("5 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  `include "tb_axil_tasks.svh"

endmodule

`default_nettype wire

/* rtl/ssd_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ssd_ctrl_top
  import ssd_ctrl_pkg::*;
#(
  parameter int unsigned WDT_TIMEOUT     = 200,  // 50_000_000 on the board
  parameter int unsigned WDT_PULSE       = 8,
  parameter int unsigned CORE_RST_CYCLES = 10
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  addr_t                   awaddr_i,
  input  logic                    awvalid_i,
  output logic                    awready_o,
  input  word_t                   wdata_i,
  input  strb_t                   wstrb_i,
  input  logic                    wvalid_i,
  output logic                    wready_o,
  output resp_t                   bresp_o,
  output logic                    bvalid_o,
  input  logic                    bready_i,
  input  addr_t                   araddr_i,
  input  logic                    arvalid_i,
  output logic                    arready_o,
  output word_t                   rdata_o,
  output resp_t                   rresp_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  input  word_t [NUM_STATE-1:0]   core_state_i,
  input  logic                    core_idle_i,
  input  logic                    io_switch_button_i,
  output logic                    cmd_valid_o,
  output word_t                   cmd_code_o,
  output word_t                   cmd_data0_o,
  output word_t                   cmd_data1_o,
  output logic                    wdt_reset_o,
  output logic                    core_switch_o,
  output logic                    core_rst_n_o
);

  logic  launch;
  word_t delay;
  logic  wdt_clear;
  logic  wdt_enable;
  logic  core_switch_q;

  axil_reg_slave u_axil_reg_slave (
    .clk          (clk),
    .rst_n        (rst_n),
    .awaddr_i     (awaddr_i),
    .awvalid_i    (awvalid_i),
    .awready_o    (awready_o),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .wvalid_i     (wvalid_i),
    .wready_o     (wready_o),
    .bresp_o      (bresp_o),
    .bvalid_o     (bvalid_o),
    .bready_i     (bready_i),
    .araddr_i     (araddr_i),
    .arvalid_i    (arvalid_i),
    .arready_o    (arready_o),
    .rdata_o      (rdata_o),
    .rresp_o      (rresp_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .core_state_i (core_state_i),
    .launch_o     (launch),
    .delay_o      (delay),
    .code_o       (cmd_code_o),
    .data0_o      (cmd_data0_o),
    .data1_o      (cmd_data1_o),
    .wdt_clear_o  (wdt_clear),
    .wdt_enable_o (wdt_enable)
  );

  cmd_launcher u_cmd_launcher (
    .clk         (clk),
    .rst_n       (rst_n),
    .launch_i    (launch),
    .delay_i     (delay),
    .cmd_valid_o (cmd_valid_o)
  );

  watchdog_timer #(
    .TIMEOUT (WDT_TIMEOUT),
    .PULSE   (WDT_PULSE)
  ) u_watchdog_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (wdt_clear),
    .enable_i    (wdt_enable),
    .wdt_reset_o (wdt_reset_o)
  );

  core_reset_ctrl #(
    .RST_CYCLES (CORE_RST_CYCLES)
  ) u_core_reset_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_idle_i  (core_idle_i),
    .core_rst_n_o (core_rst_n_o)
  );

  // watchdog or button restarts the core
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_switch_q <= 1'b0;
    end else begin
      core_switch_q <= wdt_reset_o | io_switch_button_i;
    end
  end

  assign core_switch_o = core_switch_q;

endmodule

`default_nettype wire

/* rtl/axil_reg_slave.sv */
`timescale 1ns/100ps
`default_nettype none

module axil_reg_slave
  import ssd_ctrl_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  addr_t                 awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  word_t                 wdata_i,
  input  strb_t                 wstrb_i,  // full words only
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output resp_t                 bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  input  addr_t                 araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output word_t                 rdata_o,
  output resp_t                 rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  word_t [NUM_STATE-1:0] core_state_i,
  output logic                  launch_o,
  output word_t                 delay_o,
  output word_t                 code_o,
  output word_t                 data0_o,
  output word_t                 data1_o,
  output logic                  wdt_clear_o,
  output logic                  wdt_enable_o
);

  logic       arready_q;
  logic       rvalid_q;
  word_t      rdata_q;
  reg_idx_t   rd_idx;
  logic [1:0] state_sel;
  word_t      rd_word;

  logic       awready_q;
  logic       wready_q;
  logic       aw_got_q;
  logic       w_got_q;
  logic       bvalid_q;
  logic       launch_q;
  logic       commit;
  reg_idx_t   wr_idx_q;
  word_t      wr_data_q;

  word_t      cmd_q;
  word_t      code_q;
  word_t      data0_q;
  word_t      data1_q;
  word_t      delay_q;
  logic       wdt_clear_q;
  logic       wdt_enable_q;

  assign rd_idx    = araddr_i[REG_IDX_LSB +: $bits(reg_idx_t)];
  assign state_sel = 2'(rd_idx - REG_CODE);

  // status readback
  always_comb begin
    case (rd_idx)
      REG_CMD:                                  rd_word = cmd_q;
      REG_CODE, REG_DATA0, REG_DATA1, REG_DELAY: rd_word = core_state_i[state_sel];
      default:                                  rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready_q <= 1'b1;
      rvalid_q  <= 1'b0;
    end else if (arready_q && arvalid_i) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b1;
    end else if (rvalid_q && rready_i) begin
      rvalid_q  <= 1'b0;
      arready_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (arready_q && arvalid_i) rdata_q <= rd_word;
  end

  assign commit = aw_got_q && w_got_q;

  // aw and w captured independently, commit once both are in
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awready_q    <= 1'b1;
      wready_q     <= 1'b1;
      aw_got_q     <= 1'b0;
      w_got_q      <= 1'b0;
      bvalid_q     <= 1'b0;
      launch_q     <= 1'b0;
      cmd_q        <= CMD_RESET_VALUE;
      wdt_clear_q  <= 1'b0;
      wdt_enable_q <= 1'b0;
    end else begin
      launch_q <= commit && (wr_idx_q == REG_CMD);
      if (awready_q && awvalid_i) begin
        awready_q <= 1'b0;
        aw_got_q  <= 1'b1;
      end
      if (wready_q && wvalid_i) begin
        wready_q <= 1'b0;
        w_got_q  <= 1'b1;
      end
      if (commit) begin
        aw_got_q <= 1'b0;
        w_got_q  <= 1'b0;
        bvalid_q <= 1'b1;
        case (wr_idx_q)
          REG_CMD:        cmd_q        <= wr_data_q;
          REG_WDT_CLEAR:  wdt_clear_q  <= wr_data_q[0];
          REG_WDT_ENABLE: wdt_enable_q <= wr_data_q[0];
          default: ;
        endcase
      end
      if (bvalid_q && bready_i) begin
        bvalid_q  <= 1'b0;
        awready_q <= 1'b1;  // reopen both channels
        wready_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (awready_q && awvalid_i) wr_idx_q <= awaddr_i[REG_IDX_LSB +: $bits(reg_idx_t)];
    if (wready_q && wvalid_i) wr_data_q <= wdata_i;
    if (commit) begin
      case (wr_idx_q)
        REG_CODE:  code_q  <= wr_data_q;
        REG_DATA0: data0_q <= wr_data_q;
        REG_DATA1: data1_q <= wr_data_q;
        REG_DELAY: delay_q <= wr_data_q;
        default: ;
      endcase
    end
  end

  assign arready_o    = arready_q;
  assign rvalid_o     = rvalid_q;
  assign rdata_o      = rdata_q;
  assign rresp_o      = RESP_OKAY;
  assign awready_o    = awready_q;
  assign wready_o     = wready_q;
  assign bvalid_o     = bvalid_q;
  assign bresp_o      = RESP_OKAY;
  assign launch_o     = launch_q;
  assign delay_o      = delay_q;
  assign code_o       = code_q;
  assign data0_o      = data0_q;
  assign data1_o      = data1_q;
  assign wdt_clear_o  = wdt_clear_q;
  assign wdt_enable_o = wdt_enable_q;

endmodule

`default_nettype wire

/* rtl/core_reset_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module core_reset_ctrl #(
  parameter int unsigned RST_CYCLES = 10
) (
  input  logic clk,
  input  logic rst_n,
  input  logic core_idle_i,
  output logic core_rst_n_o
);

  localparam int unsigned CNT_W = $clog2(RST_CYCLES + 1);

  logic [CNT_W-1:0] count_q;
  logic             pending_q;
  logic             core_rst_n_q;

  // a power-up request waits for the core to go idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q      <= '0;
      pending_q    <= 1'b1;
      core_rst_n_q <= 1'b1;
    end else if (pending_q && core_idle_i) begin
      if (count_q < CNT_W'(RST_CYCLES)) begin
        core_rst_n_q <= 1'b0;
        count_q      <= count_q + 1'b1;
      end else begin
        core_rst_n_q <= 1'b1;
        pending_q    <= 1'b0;  // sequence done
      end
    end else begin
      // idle lost, start over when it returns
      count_q      <= '0;
      core_rst_n_q <= 1'b1;
    end
  end

  assign core_rst_n_o = core_rst_n_q;

endmodule

`default_nettype wire

/* rtl/watchdog_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module watchdog_timer #(
  parameter int unsigned TIMEOUT = 200,
  parameter int unsigned PULSE   = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic clear_i,
  input  logic enable_i,
  output logic wdt_reset_o
);

  localparam int unsigned CNT_W   = $clog2(TIMEOUT);
  localparam int unsigned PULSE_W = $clog2(PULSE + 1);

  logic [CNT_W-1:0]   count_q;
  logic [PULSE_W-1:0] pulse_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      pulse_q <= '0;
    end else if (pulse_q != '0) begin
      // counter parked while the pulse runs
      pulse_q <= pulse_q - 1'b1;
      count_q <= '0;
    end else if (enable_i && !clear_i) begin
      if (count_q == CNT_W'(TIMEOUT - 1)) begin
        count_q <= '0;
        pulse_q <= PULSE_W'(PULSE);
      end else begin
        count_q <= count_q + 1'b1;
      end
    end else begin
      count_q <= '0;  // cleared or disabled
    end
  end

  assign wdt_reset_o = (pulse_q != '0);

endmodule

`default_nettype wire

/* rtl/cmd_launcher.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_launcher
  import ssd_ctrl_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  launch_i,
  input  word_t delay_i,
  output logic  cmd_valid_o
);

  word_t count_q;
  logic  armed_q;

  // relaunch while armed restarts the countdown
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      armed_q <= 1'b0;
    end else if (launch_i) begin
      count_q <= delay_i;
      armed_q <= 1'b1;
    end else if (armed_q) begin
      if (count_q == '0) begin
        armed_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign cmd_valid_o = armed_q && (count_q == '0);  // one cycle strobe

endmodule

`default_nettype wire

/* common/ssd_ctrl_pkg.sv */
`default_nettype none

package ssd_ctrl_pkg;

  localparam int unsigned DATA_W      = 32;
  localparam int unsigned ADDR_W      = 32;
  localparam int unsigned NUM_REGS    = 8;
  localparam int unsigned NUM_STATE   = 4;  // core state words
  localparam int unsigned REG_IDX_LSB = 2;  // word aligned

  typedef logic [DATA_W-1:0]           word_t;
  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [DATA_W/8-1:0]         strb_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
  typedef logic [1:0]                  resp_t;

  // register map
  localparam reg_idx_t REG_CMD        = 3'd0;  // write launches
  localparam reg_idx_t REG_CODE       = 3'd1;
  localparam reg_idx_t REG_DATA0      = 3'd2;
  localparam reg_idx_t REG_DATA1      = 3'd3;
  localparam reg_idx_t REG_DELAY      = 3'd4;
  localparam reg_idx_t REG_WDT_CLEAR  = 3'd5;
  localparam reg_idx_t REG_WDT_ENABLE = 3'd6;

  localparam word_t CMD_RESET_VALUE = 32'hDEADBEEF;
  localparam resp_t RESP_OKAY       = 2'b00;

endpackage

`default_nettype wire
